// ==== src/axim_cfg.svh ====
// AXI burst master configuration, bus and burst field widths

`ifndef AXIM_CFG_SVH
`define AXIM_CFG_SVH

// ---------------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------------
`define AXIM_ADDR_W 32
`define AXIM_DATA_W 64

// ---------------------------------------------------------------------------
// Burst fields
// ---------------------------------------------------------------------------
// Beat count minus one, as on the AXI len field
`define AXIM_LEN_W  5
// Log2 of bytes per beat
`define AXIM_SIZE_W 3

`endif

// ==== src/axim_pkg.sv ====
// AXI burst master shared types, transfer state and response code

package axim_pkg;

	// Per-direction transfer state
	typedef enum logic
	{
		XFER_IDLE   = 1'b0,
		XFER_ACTIVE = 1'b1
	} xfer_state_t;

	// AXI response encoding
	// Bit 1 set marks a failed access
	typedef enum logic [1:0]
	{
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_t;

endpackage

// ==== src/axim_write_engine.sv ====
// AXI write engine, one burst per init_write edge over the AW, W and B channels

`timescale 1ns/1ps

`include "axim_cfg.svh"

module axim_write_engine
(
	input  logic                      aclk,
	input  logic                      aresetn,
	input  logic                      init_write,
	input  logic                      write_enable,
	input  logic [`AXIM_ADDR_W-1:0]   write_start_address,
	input  logic [`AXIM_LEN_W-1:0]    write_burst_length,
	input  logic [`AXIM_SIZE_W-1:0]   write_burst_size,
	input  logic [`AXIM_DATA_W-1:0]   write_data,
	input  logic                      awready,
	input  logic                      wready,
	input  logic                      bvalid,
	input  axim_pkg::axi_resp_t       bresp,
	output logic                      awvalid,
	output logic [`AXIM_ADDR_W-1:0]   awaddr,
	output logic [`AXIM_LEN_W-1:0]    awlen,
	output logic [`AXIM_SIZE_W-1:0]   awsize,
	output logic                      wvalid,
	output logic                      wlast,
	output logic [`AXIM_DATA_W-1:0]   wdata,
	output logic                      bready,
	output logic                      tx_done,
	output logic                      start,
	output logic                      resp_err
);

	import axim_pkg::*;

	xfer_state_t               state;
	xfer_state_t               state_next;
	logic                      init_ff;
	logic                      init_pulse;
	logic                      busy;
	logic                      wnext;
	logic                      bnext;
	logic [`AXIM_LEN_W-1:0]    beat_idx;

	assign init_pulse = init_write && !init_ff;
	assign busy       = (state == XFER_ACTIVE);

	// Burst fields follow the request inputs
	assign awaddr = write_start_address;
	assign awlen  = write_burst_length;
	assign awsize = write_burst_size;
	assign wdata  = write_data;

	// ------------------------------------------------------------------------
	// Start edge and state machine
	// ------------------------------------------------------------------------
	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			init_ff <= 1'b0;
			start   <= 1'b0;
			state   <= XFER_IDLE;
		end
		else
		begin
			init_ff <= init_write;
			start   <= init_pulse;
			state   <= state_next;
		end
	end

	always_comb
	begin
		state_next = state;
		case (state)
			XFER_IDLE:
			begin
				if (init_pulse)
					state_next = XFER_ACTIVE;
			end
			XFER_ACTIVE:
			begin
				// A fresh edge restarts the burst
				if (tx_done && !init_pulse)
					state_next = XFER_IDLE;
			end
			default:
				state_next = XFER_IDLE;
		endcase
	end

	// ------------------------------------------------------------------------
	// Write address channel
	// ------------------------------------------------------------------------
	always_ff @(posedge aclk)
	begin
		if (!aresetn)
			awvalid <= 1'b0;
		else if (init_pulse)
			awvalid <= 1'b0;
		else if (start)
			awvalid <= 1'b1;
		else if (awready)
			awvalid <= 1'b0;
	end

	// ------------------------------------------------------------------------
	// Write data channel
	// ------------------------------------------------------------------------
	assign wnext = wvalid && wready && write_enable;
	assign wlast = wvalid && (beat_idx == write_burst_length);

	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			wvalid   <= 1'b0;
			beat_idx <= '0;
		end
		else if (init_pulse || start)
		begin
			wvalid   <= start;
			beat_idx <= '0;
		end
		else if (wnext)
		begin
			if (wlast)
				wvalid <= 1'b0;
			else
				beat_idx <= beat_idx + 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// Write response channel
	// ------------------------------------------------------------------------
	assign bnext    = bvalid && bready;
	assign resp_err = bnext && bresp[1];

	// Single-cycle bready after bvalid is seen
	always_ff @(posedge aclk)
	begin
		if (!aresetn)
			bready <= 1'b0;
		else if (init_pulse || bready)
			bready <= 1'b0;
		else if (busy && bvalid)
			bready <= 1'b1;
	end

	always_ff @(posedge aclk)
	begin
		if (!aresetn)
			tx_done <= 1'b0;
		else if (init_pulse)
			tx_done <= 1'b0;
		else if (bnext)
			tx_done <= 1'b1;
	end

endmodule

// ==== src/axim_read_engine.sv ====
// AXI read engine, one burst per init_read edge over the AR and R channels

`timescale 1ns/1ps

`include "axim_cfg.svh"

module axim_read_engine
(
	input  logic                      aclk,
	input  logic                      aresetn,
	input  logic                      init_read,
	input  logic                      read_enable,
	input  logic [`AXIM_ADDR_W-1:0]   read_start_address,
	input  logic [`AXIM_LEN_W-1:0]    read_burst_length,
	input  logic [`AXIM_SIZE_W-1:0]   read_burst_size,
	input  logic                      arready,
	input  logic                      rvalid,
	input  logic                      rlast,
	input  axim_pkg::axi_resp_t       rresp,
	output logic                      arvalid,
	output logic [`AXIM_ADDR_W-1:0]   araddr,
	output logic [`AXIM_LEN_W-1:0]    arlen,
	output logic [`AXIM_SIZE_W-1:0]   arsize,
	output logic                      rready,
	output logic                      rx_done,
	output logic                      start,
	output logic                      resp_err
);

	import axim_pkg::*;

	xfer_state_t state;
	xfer_state_t state_next;
	logic        init_ff;
	logic        init_pulse;
	logic        busy;
	logic        rnext;

	assign init_pulse = init_read && !init_ff;
	assign busy       = (state == XFER_ACTIVE);

	assign araddr = read_start_address;
	assign arlen  = read_burst_length;
	assign arsize = read_burst_size;

	// ------------------------------------------------------------------------
	// Start edge and state machine
	// ------------------------------------------------------------------------
	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			init_ff <= 1'b0;
			start   <= 1'b0;
			state   <= XFER_IDLE;
		end
		else
		begin
			init_ff <= init_read;
			start   <= init_pulse;
			state   <= state_next;
		end
	end

	always_comb
	begin
		state_next = state;
		case (state)
			XFER_IDLE:
			begin
				if (init_pulse)
					state_next = XFER_ACTIVE;
			end
			XFER_ACTIVE:
			begin
				if (rx_done && !init_pulse)
					state_next = XFER_IDLE;
			end
			default:
				state_next = XFER_IDLE;
		endcase
	end

	// ------------------------------------------------------------------------
	// Read address channel
	// ------------------------------------------------------------------------
	always_ff @(posedge aclk)
	begin
		if (!aresetn)
			arvalid <= 1'b0;
		else if (init_pulse)
			arvalid <= 1'b0;
		else if (start)
			arvalid <= 1'b1;
		else if (arready)
			arvalid <= 1'b0;
	end

	// ------------------------------------------------------------------------
	// Read data channel
	// ------------------------------------------------------------------------
	assign rnext    = rvalid && rready;
	assign resp_err = rnext && rresp[1];

	// rready lags read_enable by one cycle
	always_ff @(posedge aclk)
	begin
		if (!aresetn)
			rready <= 1'b0;
		else if (init_pulse || !read_enable)
			rready <= 1'b0;
		else if (rnext && rlast)
			rready <= 1'b0;
		else if (busy && rvalid && !rx_done)
			rready <= 1'b1;
	end

	always_ff @(posedge aclk)
	begin
		if (!aresetn)
			rx_done <= 1'b0;
		else if (init_pulse)
			rx_done <= 1'b0;
		else if (rnext && rlast)
			rx_done <= 1'b1;
	end

endmodule

// ==== src/axim_error_tracker.sv ====
// Sticky response error flag, set by either engine and cleared on either start

`timescale 1ns/1ps

module axim_error_tracker
(
	input  logic aclk,
	input  logic aresetn,
	input  logic write_start,
	input  logic read_start,
	input  logic write_resp_err,
	input  logic read_resp_err,
	output logic error
);

	logic any_start;
	logic any_err;

	assign any_start = write_start || read_start;
	assign any_err   = write_resp_err || read_resp_err;

	// ------------------------------------------------------------------------
	// Error flag
	// ------------------------------------------------------------------------
	// A new burst wins over a response in the same cycle
	always_ff @(posedge aclk)
	begin
		if (!aresetn)
			error <= 1'b0;
		else if (any_start)
			error <= 1'b0;
		else if (any_err)
			error <= 1'b1;
	end

endmodule

// ==== src/axim_top.sv ====
// AXI4 burst master top level, write and read engines with a shared error flag

`timescale 1ns/1ps

`include "axim_cfg.svh"

module axim_top
(
	input  logic                      aclk,
	input  logic                      aresetn,
	// Request side
	input  logic                      init_write,
	input  logic                      init_read,
	input  logic                      write_enable,
	input  logic                      read_enable,
	input  logic [`AXIM_ADDR_W-1:0]   write_start_address,
	input  logic [`AXIM_ADDR_W-1:0]   read_start_address,
	input  logic [`AXIM_LEN_W-1:0]    write_burst_length,
	input  logic [`AXIM_LEN_W-1:0]    read_burst_length,
	input  logic [`AXIM_SIZE_W-1:0]   write_burst_size,
	input  logic [`AXIM_SIZE_W-1:0]   read_burst_size,
	input  logic [`AXIM_DATA_W-1:0]   write_data,
	output logic                      tx_done,
	output logic                      rx_done,
	output logic                      error,
	// AXI write channels
	output logic [`AXIM_ADDR_W-1:0]   awaddr,
	output logic [`AXIM_LEN_W-1:0]    awlen,
	output logic [`AXIM_SIZE_W-1:0]   awsize,
	output logic                      awvalid,
	input  logic                      awready,
	output logic [`AXIM_DATA_W-1:0]   wdata,
	output logic                      wlast,
	output logic                      wvalid,
	input  logic                      wready,
	input  axim_pkg::axi_resp_t       bresp,
	input  logic                      bvalid,
	output logic                      bready,
	// AXI read channels
	output logic [`AXIM_ADDR_W-1:0]   araddr,
	output logic [`AXIM_LEN_W-1:0]    arlen,
	output logic [`AXIM_SIZE_W-1:0]   arsize,
	output logic                      arvalid,
	input  logic                      arready,
	input  axim_pkg::axi_resp_t       rresp,
	input  logic                      rlast,
	input  logic                      rvalid,
	output logic                      rready
);

	logic write_start;
	logic read_start;
	logic write_resp_err;
	logic read_resp_err;

	axim_write_engine i_write_engine
	(
		.aclk                (aclk),
		.aresetn             (aresetn),
		.init_write          (init_write),
		.write_enable        (write_enable),
		.write_start_address (write_start_address),
		.write_burst_length  (write_burst_length),
		.write_burst_size    (write_burst_size),
		.write_data          (write_data),
		.awready             (awready),
		.wready              (wready),
		.bvalid              (bvalid),
		.bresp               (bresp),
		.awvalid             (awvalid),
		.awaddr              (awaddr),
		.awlen               (awlen),
		.awsize              (awsize),
		.wvalid              (wvalid),
		.wlast               (wlast),
		.wdata               (wdata),
		.bready              (bready),
		.tx_done             (tx_done),
		.start               (write_start),
		.resp_err            (write_resp_err)
	);

	axim_read_engine i_read_engine
	(
		.aclk                (aclk),
		.aresetn             (aresetn),
		.init_read           (init_read),
		.read_enable         (read_enable),
		.read_start_address  (read_start_address),
		.read_burst_length   (read_burst_length),
		.read_burst_size     (read_burst_size),
		.arready             (arready),
		.rvalid              (rvalid),
		.rlast               (rlast),
		.rresp               (rresp),
		.arvalid             (arvalid),
		.araddr              (araddr),
		.arlen               (arlen),
		.arsize              (arsize),
		.rready              (rready),
		.rx_done             (rx_done),
		.start               (read_start),
		.resp_err            (read_resp_err)
	);

	axim_error_tracker i_error_tracker
	(
		.aclk                (aclk),
		.aresetn             (aresetn),
		.write_start         (write_start),
		.read_start          (read_start),
		.write_resp_err      (write_resp_err),
		.read_resp_err       (read_resp_err),
		.error               (error)
	);

endmodule

// ==== verification/axim_checker.sv ====
// AXI burst master monitor, compares bus activity with the expected burst

`timescale 1ns/1ps

`include "axim_cfg.svh"

module axim_checker
(
	input  logic                      aclk,
	input  logic                      aresetn,
	input  logic                      init_write,
	input  logic                      init_read,
	input  logic                      write_enable,
	input  logic                      read_enable,
	input  logic [`AXIM_DATA_W-1:0]   write_data,
	input  logic [`AXIM_ADDR_W-1:0]   exp_addr,
	input  logic [`AXIM_LEN_W-1:0]    exp_len,
	input  logic [`AXIM_SIZE_W-1:0]   exp_size,
	input  logic                      exp_error,
	input  logic                      awvalid,
	input  logic                      awready,
	input  logic [`AXIM_ADDR_W-1:0]   awaddr,
	input  logic [`AXIM_LEN_W-1:0]    awlen,
	input  logic [`AXIM_SIZE_W-1:0]   awsize,
	input  logic                      wvalid,
	input  logic                      wready,
	input  logic                      wlast,
	input  logic [`AXIM_DATA_W-1:0]   wdata,
	input  logic                      bready,
	input  logic                      tx_done,
	input  logic                      arvalid,
	input  logic                      arready,
	input  logic [`AXIM_ADDR_W-1:0]   araddr,
	input  logic [`AXIM_LEN_W-1:0]    arlen,
	input  logic [`AXIM_SIZE_W-1:0]   arsize,
	input  logic                      rvalid,
	input  logic                      rready,
	input  logic                      rx_done,
	input  logic                      error,
	output int                        err_count
);

	int         errs = 0;
	int         wbeats;
	int         rbeats;
	int         clr_wait;
	logic [1:0] init_w_hist;
	logic [1:0] init_r_hist;
	logic       ren_q;
	logic       tx_q;
	logic       rx_q;

	assign err_count = errs;

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED: %s got %h expected %h", name, got, exp);
			errs++;
		end
	endtask

	task automatic complain(input string what);
		$display("%s", what);
		errs++;
	endtask

	// ------------------------------------------------------------------------
	// Per-cycle checks on pre-edge values
	// ------------------------------------------------------------------------
	always @(posedge aclk)
	begin
		if (!aresetn)
		begin
			wbeats      = 0;
			rbeats      = 0;
			clr_wait    = 0;
			init_w_hist <= 2'b00;
			init_r_hist <= 2'b00;
			ren_q       <= 1'b0;
			tx_q        <= 1'b0;
			rx_q        <= 1'b0;
		end
		else
		begin
			if (awvalid && awready)
			begin
				compare("awaddr", 64'(awaddr), 64'(exp_addr));
				compare("awlen", 64'(awlen), 64'(exp_len));
				compare("awsize", 64'(awsize), 64'(exp_size));
			end
			if (arvalid && arready)
			begin
				compare("araddr", 64'(araddr), 64'(exp_addr));
				compare("arlen", 64'(arlen), 64'(exp_len));
				compare("arsize", 64'(arsize), 64'(exp_size));
			end
			if (wvalid && wready && write_enable)
			begin
				compare("wdata", wdata, write_data);
				compare("wlast", 64'(wlast), 64'(wbeats == int'(exp_len)));
				wbeats++;
			end
			// rready is registered, so it reflects read_enable one cycle back
			if (rvalid && rready)
			begin
				if (!ren_q)
					complain("Read beat accepted while read_enable was low");
				rbeats++;
			end
			if (tx_done && !tx_q)
			begin
				compare("write beat count", 64'(wbeats), 64'(int'(exp_len) + 1));
				compare("error", 64'(error), 64'(exp_error));
			end
			if (rx_done && !rx_q)
			begin
				compare("read beat count", 64'(rbeats), 64'(int'(exp_len) + 1));
				compare("error", 64'(error), 64'(exp_error));
			end
			if (tx_done && (awvalid || wvalid || bready))
				complain("Write channel still active after tx_done");
			if (rx_done && (arvalid || rready))
				complain("Read channel still active after rx_done");
			if (tx_q && !tx_done && init_w_hist != 2'b01)
				complain("tx_done dropped without a new write start");
			if (rx_q && !rx_done && init_r_hist != 2'b01)
				complain("rx_done dropped without a new read start");

			// Error clears two cycles after a start edge
			if (clr_wait > 0)
			begin
				clr_wait--;
				if (clr_wait == 0)
					compare("error after start", 64'(error), 64'd0);
			end
			if (init_write && !init_w_hist[0])
			begin
				wbeats   = 0;
				clr_wait = 2;
			end
			if (init_read && !init_r_hist[0])
			begin
				rbeats   = 0;
				clr_wait = 2;
			end

			init_w_hist <= {init_w_hist[0], init_write};
			init_r_hist <= {init_r_hist[0], init_read};
			ren_q       <= read_enable;
			tx_q        <= tx_done;
			rx_q        <= rx_done;
		end
	end

endmodule

// ==== verification/tb_axim_top.sv ====
// AXI burst master testbench with burst table, slave model and DUT

`timescale 1ns/1ps

`include "axim_cfg.svh"

module tb_axim_top;

	import axim_pkg::*;

	localparam int NUM_ROWS = 8;
	localparam int TIMEOUT  = 600;

	logic                    aclk;
	logic                    aresetn;
	logic                    init_write;
	logic                    init_read;
	logic                    write_enable;
	logic                    read_enable;
	logic [`AXIM_ADDR_W-1:0] write_start_address;
	logic [`AXIM_ADDR_W-1:0] read_start_address;
	logic [`AXIM_LEN_W-1:0]  write_burst_length;
	logic [`AXIM_LEN_W-1:0]  read_burst_length;
	logic [`AXIM_SIZE_W-1:0] write_burst_size;
	logic [`AXIM_SIZE_W-1:0] read_burst_size;
	logic [`AXIM_DATA_W-1:0] write_data;
	logic                    tx_done;
	logic                    rx_done;
	logic                    error;
	logic [`AXIM_ADDR_W-1:0] awaddr;
	logic [`AXIM_LEN_W-1:0]  awlen;
	logic [`AXIM_SIZE_W-1:0] awsize;
	logic                    awvalid;
	logic                    awready;
	logic [`AXIM_DATA_W-1:0] wdata;
	logic                    wlast;
	logic                    wvalid;
	logic                    wready;
	axi_resp_t               bresp;
	logic                    bvalid;
	logic                    bready;
	logic [`AXIM_ADDR_W-1:0] araddr;
	logic [`AXIM_LEN_W-1:0]  arlen;
	logic [`AXIM_SIZE_W-1:0] arsize;
	logic                    arvalid;
	logic                    arready;
	axi_resp_t               rresp;
	logic                    rlast;
	logic                    rvalid;
	logic                    rready;

	// Stimulus table where dir 1 marks a read
	logic                    row_dir    [NUM_ROWS];
	logic [`AXIM_ADDR_W-1:0] row_addr   [NUM_ROWS];
	logic [`AXIM_LEN_W-1:0]  row_len    [NUM_ROWS];
	logic [`AXIM_SIZE_W-1:0] row_size   [NUM_ROWS];
	axi_resp_t               row_resp   [NUM_ROWS];
	logic                    row_toggle [NUM_ROWS];
	logic                    row_exp    [NUM_ROWS];

	logic [`AXIM_ADDR_W-1:0] exp_addr;
	logic [`AXIM_LEN_W-1:0]  exp_len;
	logic [`AXIM_SIZE_W-1:0] exp_size;
	logic                    exp_error;
	axi_resp_t               cur_resp;
	int                      checker_errs;
	logic                    timeout_hit;
	logic                    done;
	int                      row;
	int                      cycles;

	// Slave model state
	logic                    aw_seen;
	logic                    wl_seen;
	logic                    r_active;
	int                      r_beat;
	logic [`AXIM_LEN_W-1:0]  r_len;

	axim_top i_dut (.*);

	axim_checker i_checker
	(
		.err_count (checker_errs),
		.*
	);

	initial
	begin
		aclk = 1'b0;
		forever
			#20 aclk = ~aclk;
	end

	always @(posedge aclk)
		write_data <= {$urandom, $urandom};

	// ------------------------------------------------------------------------
	// Slave model with random ready and valid delays
	// ------------------------------------------------------------------------
	always @(posedge aclk)
	begin
		if (!aresetn)
		begin
			awready  <= 1'b0;
			wready   <= 1'b0;
			arready  <= 1'b0;
			bvalid   <= 1'b0;
			bresp    <= RESP_OKAY;
			rvalid   <= 1'b0;
			rlast    <= 1'b0;
			rresp    <= RESP_OKAY;
			aw_seen  = 1'b0;
			wl_seen  = 1'b0;
			r_active = 1'b0;
			r_beat   = 0;
			r_len    = '0;
		end
		else
		begin
			awready <= ($urandom % 3) != 0;
			wready  <= ($urandom % 3) != 0;
			arready <= ($urandom % 3) != 0;
			if (awvalid && awready)
				aw_seen = 1'b1;
			if (wvalid && wready && write_enable && wlast)
				wl_seen = 1'b1;
			if (bvalid && bready)
			begin
				bvalid  <= 1'b0;
				aw_seen = 1'b0;
				wl_seen = 1'b0;
			end
			else if (aw_seen && wl_seen)
			begin
				bvalid <= 1'b1;
				bresp  <= cur_resp;
			end

			if (arvalid && arready)
			begin
				r_active = 1'b1;
				r_beat   = 0;
				r_len    = arlen;
			end
			if (rvalid && rready)
			begin
				if (rlast)
					r_active = 1'b0;
				r_beat++;
			end
			// A presented beat holds until it is taken
			if (r_active && (!rvalid || rready))
			begin
				rvalid <= ($urandom % 4) != 0;
				rlast  <= (r_beat == int'(r_len));
				rresp  <= cur_resp;
			end
			else if (!r_active)
			begin
				rvalid <= 1'b0;
				rlast  <= 1'b0;
			end
		end
	end

	task automatic set_row(input int i, input logic dir, input logic [31:0] addr,
		input logic [4:0] len, input logic [2:0] size, input axi_resp_t resp,
		input logic toggle, input logic exp_err);
		row_dir[i]    = dir;
		row_addr[i]   = addr;
		row_len[i]    = len;
		row_size[i]   = size;
		row_resp[i]   = resp;
		row_toggle[i] = toggle;
		row_exp[i]    = exp_err;
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial
	begin
		void'($urandom(32'he6c9));
		aresetn             = 1'b0;
		init_write          = 1'b0;
		init_read           = 1'b0;
		write_enable        = 1'b1;
		read_enable         = 1'b1;
		write_start_address = '0;
		read_start_address  = '0;
		write_burst_length  = '0;
		read_burst_length   = '0;
		write_burst_size    = '0;
		read_burst_size     = '0;
		write_data          = '0;
		awready             = 1'b0;
		wready              = 1'b0;
		arready             = 1'b0;
		bvalid              = 1'b0;
		bresp               = RESP_OKAY;
		rvalid              = 1'b0;
		rlast               = 1'b0;
		rresp               = RESP_OKAY;
		exp_addr            = '0;
		exp_len             = '0;
		exp_size            = '0;
		exp_error           = 1'b0;
		cur_resp            = RESP_OKAY;
		timeout_hit         = 1'b0;

		set_row(0, 1'b0, 32'h0000_1000, 5'd3,  3'd3, RESP_OKAY,   1'b0, 1'b0);
		set_row(1, 1'b0, 32'h0000_2040, 5'd7,  3'd3, RESP_SLVERR, 1'b1, 1'b1);
		set_row(2, 1'b1, 32'h0001_0000, 5'd0,  3'd2, RESP_OKAY,   1'b0, 1'b0);
		set_row(3, 1'b1, 32'h0001_8000, 5'd7,  3'd3, RESP_DECERR, 1'b1, 1'b1);
		set_row(4, 1'b0, 32'h0002_0000, 5'd0,  3'd3, RESP_EXOKAY, 1'b0, 1'b0);
		set_row(5, 1'b1, 32'h0003_0100, 5'd15, 3'd3, RESP_OKAY,   1'b1, 1'b0);
		set_row(6, 1'b0, 32'h0004_0000, 5'd31, 3'd3, RESP_DECERR, 1'b1, 1'b1);
		set_row(7, 1'b1, 32'h0005_0000, 5'd4,  3'd1, RESP_SLVERR, 1'b0, 1'b1);

		repeat (4) @(posedge aclk);
		aresetn <= 1'b1;
		repeat (2) @(posedge aclk);

		for (row = 0; row < NUM_ROWS; row++)
		begin
			@(posedge aclk);
			exp_addr  <= row_addr[row];
			exp_len   <= row_len[row];
			exp_size  <= row_size[row];
			exp_error <= row_exp[row];
			cur_resp  <= row_resp[row];
			if (row_dir[row])
			begin
				read_start_address <= row_addr[row];
				read_burst_length  <= row_len[row];
				read_burst_size    <= row_size[row];
				init_read          <= 1'b1;
			end
			else
			begin
				write_start_address <= row_addr[row];
				write_burst_length  <= row_len[row];
				write_burst_size    <= row_size[row];
				init_write          <= 1'b1;
			end
			@(posedge aclk);
			init_write <= 1'b0;
			init_read  <= 1'b0;

			done = 1'b0;
			for (cycles = 0; cycles < TIMEOUT && !done; cycles++)
			begin
				@(posedge aclk);
				// Enable drop lands inside the burst
				if (row_toggle[row] && cycles == 3)
				begin
					write_enable <= 1'b0;
					read_enable  <= 1'b0;
				end
				if (cycles == 7)
				begin
					write_enable <= 1'b1;
					read_enable  <= 1'b1;
				end
				done = row_dir[row] ? rx_done : tx_done;
			end
			write_enable <= 1'b1;
			read_enable  <= 1'b1;
			if (!done)
			begin
				$display("Timeout waiting for burst completion in row %0d", row);
				timeout_hit = 1'b1;
				break;
			end
			repeat (3) @(posedge aclk);
		end

		$display("Run complete with %0d check errors and %0d timeouts",
			checker_errs, timeout_hit ? 1 : 0);
		if (checker_errs == 0 && !timeout_hit)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+src
src/axim_pkg.sv
src/axim_write_engine.sv
src/axim_read_engine.sv
src/axim_error_tracker.sv
src/axim_top.sv
verification/axim_checker.sv
verification/tb_axim_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AXI burst master simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_axim_top -f sources.f -o sim_axim

output="$(./obj_dir/sim_axim)"
echo "$output"

if echo "$output" | grep -qx "No errors"; then
	exit 0
else
	exit 1
fi
